// File: runner_macros.svh
`ifndef RUNNER_MACROS_SVH
`define RUNNER_MACROS_SVH

// obstacle word: 3 bit kind, 2 bit lane, depth of the obstacle's far end
`define OBS_WIDTH        16
`define DEPTH_WIDTH      11

// player state widths
`define HEIGHT_WIDTH     16    // signed
`define SCORE_WIDTH      16

// vertical geometry, in height units
`define GROUND           (-128) // floor level, no train car underneath
`define LOW_CLEAR        64     // clearance over ground that gets past a low barrier

`define NUM_LANES        3

// frame pacing in clk_render cycles
`define MIN_FRAME_CYCLES 128
`define LAG_UNIT         16     // extra cycles per step of frame_lag

// obstacle buffer
`define FIFO_DEPTH       16

`endif

// File: runner_pkg.sv
`default_nettype none

`include "runner_macros.svh"

package runner_pkg;

    // kinds above OBS_TRAIN are scenery
    typedef enum logic [2:0] {
        OBS_LOW   = 3'd0,   // barrier, jump over it
        OBS_HIGH  = 3'd1,   // overhead bar, duck under it
        OBS_TRAIN = 3'd2    // no way past
    } obstacle_kind_e;

    typedef struct packed {
        obstacle_kind_e           kind;
        logic [1:0]               lane;
        logic [`DEPTH_WIDTH-1:0]  depth; // end of the obstacle, 0 is the first row
    } obstacle_t;

    // pending rising edges, bit order matches the button bus
    typedef struct packed {
        logic left;
        logic duck;
        logic jump;
        logic right;
    } controls_t;

    typedef struct packed {
        logic [5:0] gravity;        // velocity lost per frame, 128ths
        logic [7:0] duck_limit;     // frames a duck lasts
        logic [9:0] vertical_jump;  // launch velocity, 128ths
    } physics_t;

    // faster games get shorter ducks and snappier jumps
    function automatic physics_t speed_physics(input logic [3:0] speed);
        physics_t p;
        if (speed[3]) begin
            p = '{gravity: 6'd60, duck_limit: 8'd16, vertical_jump: 10'd360};
        end else if (speed[2]) begin
            p = '{gravity: 6'd15, duck_limit: 8'd32, vertical_jump: 10'd470};
        end else if (speed[1]) begin
            p = '{gravity: 6'd4, duck_limit: 8'd64, vertical_jump: 10'd220};
        end else if (speed[0]) begin
            p = '{gravity: 6'd1, duck_limit: 8'd128, vertical_jump: 10'd108};
        end else begin
            p = '0; // stopped game, nothing moves
        end
        return p;
    endfunction

endpackage

`default_nettype wire

// File: frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "runner_macros.svh"

// paces the game: one new_frame pulse per frame period
module frame_sequencer (
    input  wire        clk_render,
    input  wire        rst_n,
    input  wire  [7:0] frame_lag,   // slows the game down in LAG_UNIT steps
    output logic       new_frame
);

    // longest period is with frame_lag at 255
    localparam int MAX_PERIOD = `MIN_FRAME_CYCLES + 255 * `LAG_UNIT;
    localparam int CNT_W      = $clog2(MAX_PERIOD + 1);

    logic [CNT_W-1:0] cycle_cnt;
    logic [CNT_W-1:0] period;       // length of the frame in progress
    logic [CNT_W-1:0] next_period;
    logic             frame_end;

    assign next_period = CNT_W'(`MIN_FRAME_CYCLES)
                       + CNT_W'(frame_lag) * CNT_W'(`LAG_UNIT);

    // last cycle of the current frame
    assign frame_end = (cycle_cnt == period - 1'b1);

    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            period    <= CNT_W'(`MIN_FRAME_CYCLES); // first frame has no lag
            new_frame <= 1'b0;
        end else begin
            new_frame <= frame_end;                // registered, exactly one cycle wide
            if (frame_end) begin
                cycle_cnt <= '0;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
            // lag is taken while the pulse is out, counter already restarted
            if (new_frame) begin
                period <= next_period;
            end
        end
    end

endmodule

`default_nettype wire

// File: control_capture.sv
`timescale 1ns/1ps
`default_nettype none

// debounce the four buttons and keep each press until a frame consumes it
module control_capture #(
    parameter int DEBOUNCE_CYCLES = 100_000
) (
    input  wire                    clk_render,
    input  wire                    rst_n,
    input  wire  [3:0]             btn,        // left, duck, jump, right
    input  wire                    new_frame,
    output runner_pkg::controls_t  controls    // held rising edges
);

    import runner_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [3:0] clean;     // debounced levels
    logic [3:0] clean_q;   // clean levels one cycle back
    logic [3:0] rise;

    for (genvar i = 0; i < 4; i++) begin : g_debounce
        logic [CNT_W-1:0] stable_cnt;  // cycles the raw level has disagreed with clean
        logic             clean_bit;

        always_ff @(posedge clk_render or negedge rst_n) begin
            if (!rst_n) begin
                stable_cnt <= '0;
                clean_bit  <= 1'b0;
            end else if (btn[i] == clean_bit) begin
                stable_cnt <= '0;                  // bounce back, start over
            end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                stable_cnt <= '0;
                clean_bit  <= btn[i];              // new level has held long enough
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end

        assign clean[i] = clean_bit;
    end

    assign rise = clean & ~clean_q;

    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            clean_q  <= '0;
            controls <= '0;
        end else begin
            clean_q <= clean;
            if (new_frame) begin
                // frame just read the held edges, an edge arriving now waits for the next one
                controls <= controls_t'(rise);
            end else begin
                controls <= controls_t'(controls | rise);
            end
        end
    end

endmodule

`default_nettype wire

// File: obstacle_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "runner_macros.svh"

// synchronous fifo, head word shown combinationally while not empty
module obstacle_fifo #(
    parameter type payload_t = logic [`OBS_WIDTH-1:0],
    parameter int  DEPTH     = `FIFO_DEPTH
) (
    input  wire           clk_render,
    input  wire           rst_n,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      pop_data,
    output logic          empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // words stored
    logic             full;
    logic             do_push;
    logic             do_pop;

    // wraps for any depth, not just powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;   // overflow word is lost
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk_render) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

    // consumer must watch empty
    a_no_pop_empty: assert property (
        @(posedge clk_render) disable iff (!rst_n) pop |-> !empty
    ) else $error("obstacle_fifo: pop while empty");

    // no back-pressure toward the source, so a full buffer means a lost obstacle
    a_no_push_full: assert property (
        @(posedge clk_render) disable iff (!rst_n) push |-> !full
    ) else $error("obstacle_fifo: push into full buffer, word dropped");

endmodule

`default_nettype wire

// File: runner_game.sv
`timescale 1ns/1ps
`default_nettype none

`include "runner_macros.svh"

// player state, per-frame physics and collision against buffered obstacles
module runner_game (
    input  wire                              clk_render,
    input  wire                              rst_n,
    input  wire                              new_frame,
    input  wire  runner_pkg::controls_t      controls,
    input  wire  [3:0]                       speed,
    input  wire  runner_pkg::obstacle_t      pop_data,
    input  wire                              empty,
    output logic                             pop,
    output logic                             game_over,
    output logic [1:0]                       player_lane,
    output logic signed [`HEIGHT_WIDTH-1:0]  player_height,
    output logic [`SCORE_WIDTH-1:0]          player_score,
    output logic                             ducking
);

    import runner_pkg::*;

    localparam logic [1:0] LANE_MAX = 2'(`NUM_LANES - 1);
    localparam logic signed [`HEIGHT_WIDTH-1:0] GROUND_H  = `HEIGHT_WIDTH'(`GROUND);
    localparam logic signed [`HEIGHT_WIDTH-1:0] LOW_LIMIT = `HEIGHT_WIDTH'(`GROUND + `LOW_CLEAR);

    physics_t                        phys;
    logic signed [`HEIGHT_WIDTH-1:0] velocity;     // 128ths of a height unit per frame
    logic [7:0]                      duck_timer;   // frames of duck left
    logic [7:0]                      duck_next;
    logic [1:0]                      lane_next;
    logic signed [`HEIGHT_WIDTH-1:0] vel_start;
    logic signed [`HEIGHT_WIDTH-1:0] vel_step;
    logic signed [`HEIGHT_WIDTH-1:0] height_step;
    logic                            landed;
    logic                            hit;

    assign phys    = speed_physics(speed);
    assign ducking = (duck_timer != '0);
    assign pop     = !empty && !new_frame;      // drain every cycle except the frame update cycle

    // opposite presses cancel the lane change
    always_comb begin
        lane_next = player_lane;
        if (controls.left && !controls.right && player_lane != 2'd0) begin
            lane_next = player_lane - 1'b1;
        end else if (controls.right && !controls.left && player_lane != LANE_MAX) begin
            lane_next = player_lane + 1'b1;
        end
    end

    // a new duck restarts the timer
    assign duck_next = controls.duck ? phys.duck_limit
                     : (duck_timer != '0) ? duck_timer - 1'b1 : 8'd0;

    always_comb begin
        // jump only from the floor
        vel_start = (controls.jump && player_height == GROUND_H)
                  ? $signed(`HEIGHT_WIDTH'(phys.vertical_jump)) : velocity;
        height_step = player_height + (vel_start >>> 7);
        vel_step    = vel_start - $signed(`HEIGHT_WIDTH'(phys.gravity));
        landed      = (height_step <= GROUND_H);
    end

    // only the first row can touch the player
    always_comb begin
        hit = 1'b0;
        if (pop && pop_data.depth == '0 && pop_data.lane == player_lane) begin
            case (pop_data.kind)
                OBS_TRAIN: hit = 1'b1;
                OBS_HIGH:  hit = !ducking;
                OBS_LOW:   hit = (player_height < LOW_LIMIT); // not high enough yet
                default:   hit = 1'b0;                        // scenery
            endcase
        end
    end

    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            game_over     <= 1'b0;
            player_lane   <= 2'd1;        // middle lane
            player_height <= GROUND_H;
            velocity      <= '0;
            player_score  <= '0;
            duck_timer    <= '0;
        end else if (!game_over) begin
            if (new_frame) begin
                player_score  <= player_score + `SCORE_WIDTH'(speed);
                player_lane   <= lane_next;
                duck_timer    <= duck_next;
                player_height <= landed ? GROUND_H : height_step;
                velocity      <= landed ? '0 : vel_step;
            end
            if (hit) begin
                game_over <= 1'b1;      // pop never shares a cycle with new_frame
            end
        end
    end

    a_lane_range: assert property (
        @(posedge clk_render) disable iff (!rst_n) player_lane <= LANE_MAX
    ) else $error("runner_game: lane out of range");

endmodule

`default_nettype wire

// File: runner_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "runner_macros.svh"

// game core: frame pacing, button capture, obstacle buffer and game logic
module runner_core #(
    parameter int DEBOUNCE_CYCLES = 100_000
) (
    input  wire                              clk_render,
    input  wire                              rst_n,
    input  wire  [3:0]                       btn,            // left, duck, jump, right
    input  wire  [3:0]                       speed,
    input  wire  [7:0]                       frame_lag,
    input  wire  runner_pkg::obstacle_t      obstacle,
    input  wire                              obstacle_valid,
    output logic                             new_frame,
    output logic                             game_over,
    output logic [1:0]                       player_lane,
    output logic signed [`HEIGHT_WIDTH-1:0]  player_height,
    output logic [`SCORE_WIDTH-1:0]          player_score,
    output logic                             ducking
);

    import runner_pkg::*;

    controls_t controls;     // edges waiting for the next frame
    obstacle_t fifo_head;
    logic      fifo_empty;
    logic      fifo_pop;

    frame_sequencer frame_sequencer_i (
        .clk_render (clk_render),
        .rst_n      (rst_n),
        .frame_lag  (frame_lag),
        .new_frame  (new_frame)
    );

    control_capture #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) control_capture_i (
        .clk_render (clk_render),
        .rst_n      (rst_n),
        .btn        (btn),
        .new_frame  (new_frame),
        .controls   (controls)
    );

    obstacle_fifo #(
        .payload_t (obstacle_t),
        .DEPTH     (`FIFO_DEPTH)
    ) obstacle_fifo_i (
        .clk_render (clk_render),
        .rst_n      (rst_n),
        .push       (obstacle_valid),   // source strobe, no ready back
        .push_data  (obstacle),
        .pop        (fifo_pop),
        .pop_data   (fifo_head),
        .empty      (fifo_empty)
    );

    runner_game runner_game_i (
        .clk_render    (clk_render),
        .rst_n         (rst_n),
        .new_frame     (new_frame),
        .controls      (controls),
        .speed         (speed),
        .pop_data      (fifo_head),
        .empty         (fifo_empty),
        .pop           (fifo_pop),
        .game_over     (game_over),
        .player_lane   (player_lane),
        .player_height (player_height),
        .player_score  (player_score),
        .ducking       (ducking)
    );

endmodule

`default_nettype wire

// File: tb_runner_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "runner_macros.svh"

module tb_runner_core;

    import runner_pkg::*;

    localparam int FRAME_TIMEOUT = 4 * `MIN_FRAME_CYCLES;   // cycles to wait for new_frame
    localparam int HIT_WINDOW    = 8;                       // worst case from push to game_over
    localparam int HOLD_CYCLES   = 12;                      // button held down per press

    logic                            clk_render;
    logic                            rst_n;
    logic [3:0]                      btn;
    logic [3:0]                      speed;
    logic [7:0]                      frame_lag;
    obstacle_t                       obstacle;
    logic                            obstacle_valid;
    logic                            new_frame;
    logic                            game_over;
    logic [1:0]                      player_lane;
    logic signed [`HEIGHT_WIDTH-1:0] player_height;
    logic [`SCORE_WIDTH-1:0]         player_score;
    logic                            ducking;

    // player state model advanced once per frame
    int                      m_lane;
    int                      m_height;
    int                      m_vel;      // 128ths per frame
    int                      m_duck;     // frames of duck left
    logic [`SCORE_WIDTH-1:0] m_score;
    logic                    m_over;

    runner_core #(
        .DEBOUNCE_CYCLES (8)
    ) dut_i (
        .clk_render     (clk_render),
        .rst_n          (rst_n),
        .btn            (btn),
        .speed          (speed),
        .frame_lag      (frame_lag),
        .obstacle       (obstacle),
        .obstacle_valid (obstacle_valid),
        .new_frame      (new_frame),
        .game_over      (game_over),
        .player_lane    (player_lane),
        .player_height  (player_height),
        .player_score   (player_score),
        .ducking        (ducking)
    );

    initial begin
        clk_render = 1'b0;
        forever #10 clk_render = ~clk_render;   // 50 MHz
    end

    task automatic abort_run(input string why);
        $display("Result: FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_height(input string name, input logic signed [`HEIGHT_WIDTH-1:0] got,
                                input logic signed [`HEIGHT_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("height mismatch");
        end
    endtask

    task automatic check_lane(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("lane mismatch");
        end
    endtask

    task automatic check_score(input string name, input logic [`SCORE_WIDTH-1:0] got,
                               input logic [`SCORE_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("score mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("flag mismatch");
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run("frame timing mismatch");
        end
    endtask

    // gravity, duck length and launch speed by speed range
    function automatic physics_t model_physics(input logic [3:0] spd);
        physics_t p;
        p = '0;                                                     // stopped
        if (spd == 4'd1) begin
            p.gravity       = 6'd1;
            p.duck_limit    = 8'd128;
            p.vertical_jump = 10'd108;
        end else if (spd >= 4'd2 && spd <= 4'd3) begin
            p.gravity       = 6'd4;
            p.duck_limit    = 8'd64;
            p.vertical_jump = 10'd220;
        end else if (spd >= 4'd4 && spd <= 4'd7) begin
            p.gravity       = 6'd15;
            p.duck_limit    = 8'd32;
            p.vertical_jump = 10'd470;
        end else if (spd >= 4'd8) begin
            p.gravity       = 6'd60;
            p.duck_limit    = 8'd16;
            p.vertical_jump = 10'd360;
        end
        return p;
    endfunction

    task automatic model_frame(input controls_t c);
        physics_t p;
        p = model_physics(speed);
        if (!m_over) begin
            m_score = m_score + `SCORE_WIDTH'(speed);
            if (c.left && !c.right && m_lane > 0) m_lane = m_lane - 1;
            else if (c.right && !c.left && m_lane < `NUM_LANES - 1) m_lane = m_lane + 1;
            if (c.duck) m_duck = int'(p.duck_limit);
            else if (m_duck > 0) m_duck = m_duck - 1;
            if (c.jump && m_height == `GROUND) m_vel = int'(p.vertical_jump);
            m_height = m_height + (m_vel >>> 7);
            m_vel    = m_vel - int'(p.gravity);
            if (m_height <= `GROUND) begin
                m_height = `GROUND;                             // back on the floor
                m_vel    = 0;
            end
        end
    endtask

    task automatic check_state;
        check_score("player_score", player_score, m_score);
        check_lane("player_lane", player_lane, 2'(m_lane));
        check_height("player_height", player_height, `HEIGHT_WIDTH'(m_height));
        check_flag("ducking", ducking, m_duck != 0);
        check_flag("game_over", game_over, m_over);
    endtask

    // counts negedges until new_frame is seen high
    task automatic count_frame_cycles(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_render);
            cycles++;
        end while (!new_frame && cycles <= FRAME_TIMEOUT);
        if (!new_frame) begin
            $display("timeout: no new_frame pulse within %0d cycles", FRAME_TIMEOUT);
            abort_run("frame timeout");
        end
    endtask

    // returns one negedge after the frame update has been clocked in
    task automatic wait_frame;
        int cycles;
        cycles = 0;
        @(negedge clk_render);
        while (!new_frame) begin
            if (cycles >= FRAME_TIMEOUT) begin
                $display("timeout: no new_frame pulse within %0d cycles", FRAME_TIMEOUT);
                abort_run("frame timeout");
            end else begin
                cycles++;
                @(negedge clk_render);
            end
        end
        @(negedge clk_render);
    endtask

    task automatic next_frame(input controls_t c);
        wait_frame();
        model_frame(c);
        check_state();
    endtask

    // start right after a frame so the edge is taken by the following one
    task automatic press(input controls_t c);
        btn = c;
        repeat (HOLD_CYCLES) @(negedge clk_render);
        btn = '0;
        next_frame(c);
    endtask

    task automatic push_obstacle(input obstacle_kind_e kind, input logic [1:0] lane,
                                 input logic [`DEPTH_WIDTH-1:0] depth, input logic exp_hit);
        int cycles;
        cycles = 0;
        obstacle       = '{kind: kind, lane: lane, depth: depth};
        obstacle_valid = 1'b1;
        @(negedge clk_render);
        obstacle_valid = 1'b0;
        while (!game_over && cycles < HIT_WINDOW) begin
            cycles++;
            @(negedge clk_render);
        end
        if (exp_hit) begin
            if (!game_over) begin
                $display("game_over did not rise within %0d cycles of the push", HIT_WINDOW);
                abort_run("missed collision");
            end
            m_over = 1'b1;
        end else begin
            check_flag("game_over", game_over, 1'b0);
        end
    endtask

    task automatic test_reset;
        int cycles;
        check_state();                                      // model holds the reset values
        check_height("player_height", player_height, `HEIGHT_WIDTH'(`GROUND));
        count_frame_cycles(cycles);                         // first frame runs without lag
        check_cycles("new_frame delay", cycles, `MIN_FRAME_CYCLES);
        frame_lag = 8'd3;                                   // taken while the pulse is high
        count_frame_cycles(cycles);
        check_cycles("new_frame period", cycles, `MIN_FRAME_CYCLES + 3 * `LAG_UNIT);
        frame_lag = '0;
        @(negedge clk_render);                              // second frame update is in
        model_frame('0);
        model_frame('0);
        check_state();
    endtask

    task automatic test_score_lanes;
        logic [`SCORE_WIDTH-1:0] prev;
        speed = 4'd4;
        repeat (2) begin
            prev = m_score;
            next_frame('0);
            check_score("player_score", player_score, prev + `SCORE_WIDTH'(4));
        end
        press('{left: 1'b1, duck: 1'b0, jump: 1'b0, right: 1'b0});
        press('{left: 1'b1, duck: 1'b0, jump: 1'b0, right: 1'b0});    // stays at 0
        check_lane("player_lane", player_lane, 2'd0);
        press('{left: 1'b1, duck: 1'b0, jump: 1'b0, right: 1'b1});    // cancels
        repeat (3) press('{left: 1'b0, duck: 1'b0, jump: 1'b0, right: 1'b1});
        check_lane("player_lane", player_lane, 2'd2);
    endtask

    task automatic test_jump;
        int frames;
        frames = 0;
        speed  = 4'd4;
        press('{left: 1'b0, duck: 1'b0, jump: 1'b1, right: 1'b0});
        while (m_height != `GROUND && frames < 100) begin
            next_frame('0);
            frames++;
        end
        check_height("player_height", player_height, `HEIGHT_WIDTH'(`GROUND));
    endtask

    task automatic test_duck;
        speed = 4'd8;
        press('{left: 1'b0, duck: 1'b1, jump: 1'b0, right: 1'b0});
        repeat (15) next_frame('0);
        check_flag("ducking", ducking, 1'b1);                       // 16th frame of duck
        next_frame('0);
        check_flag("ducking", ducking, 1'b0);
    endtask

    task automatic test_collisions;
        logic [1:0]              own;
        logic [`SCORE_WIDTH-1:0] saved_score;
        int                      frames;
        own = 2'(m_lane);
        push_obstacle(OBS_TRAIN, 2'((m_lane + 1) % `NUM_LANES), '0, 1'b0);
        push_obstacle(OBS_TRAIN, own, 11'd9, 1'b0);                 // not at the first row yet
        push_obstacle(obstacle_kind_e'(3'd6), own, '0, 1'b0);       // scenery
        press('{left: 1'b0, duck: 1'b1, jump: 1'b0, right: 1'b0});
        push_obstacle(OBS_HIGH, own, '0, 1'b0);

        // jump, then freeze gravity with speed 0 so the player climbs past the barrier
        speed = 4'd4;
        press('{left: 1'b0, duck: 1'b0, jump: 1'b1, right: 1'b0});
        speed  = 4'd0;
        frames = 0;
        while (m_height < `GROUND + `LOW_CLEAR && frames < 60) begin
            next_frame('0);
            frames++;
        end
        push_obstacle(OBS_LOW, own, '0, 1'b0);
        speed  = 4'd4;
        frames = 0;
        while (m_height != `GROUND && frames < 200) begin
            next_frame('0);
            frames++;
        end

        push_obstacle(OBS_TRAIN, own, '0, 1'b1);
        saved_score = m_score;
        repeat (2) next_frame('0);
        press('{left: 1'b1, duck: 1'b0, jump: 1'b0, right: 1'b0});    // ignored after game over
        check_score("player_score", player_score, saved_score);
        check_lane("player_lane", player_lane, own);
        check_flag("game_over", game_over, 1'b1);
    endtask

    initial begin
        btn            = '0;
        speed          = '0;
        frame_lag      = '0;
        obstacle       = '0;
        obstacle_valid = 1'b0;
        rst_n          = 1'b0;
        m_lane         = 1;
        m_height       = `GROUND;
        m_vel          = 0;
        m_duck         = 0;
        m_score        = '0;
        m_over         = 1'b0;
        repeat (16) @(negedge clk_render);
        rst_n = 1'b1;

        test_reset();
        test_score_lanes();
        test_jump();
        test_duck();
        test_collisions();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: runner_core.f
+incdir+.
runner_pkg.sv
frame_sequencer.sv
control_capture.sv
obstacle_fifo.sv
runner_game.sv
runner_core.sv
tb_runner_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the runner core testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_runner_core \
    -f runner_core.f \
    -o sim_runner_core

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/sim_runner_core
